// ==== phy_read_datapath.f ====
source/phy_read_cfg_pkg.sv
source/phy_read_types_pkg.sv
source/read_latency_shifter.sv
source/read_latency_calibrator.sv
source/read_valid_selector.sv
source/phy_read_datapath.sv
tb/phy_read_datapath_tb.sv

// ==== source/phy_read_cfg_pkg.sv ====
// read path constants: latency count width, tap count, data width, calibration pattern and window
package phy_read_cfg_pkg;

	// the latency count selects one of the shifter taps
	localparam int LATENCY_COUNT_WIDTH = 4;

	// one tap per possible latency count value
	localparam int LATENCY_NUM = 2 ** LATENCY_COUNT_WIDTH;

	// width of a single AFI read word
	localparam int DATA_WIDTH = 32;

	// calibration reads expect this word back from the memory
	localparam logic [DATA_WIDTH-1:0] CAL_PATTERN = 32'ha5c3_3c5a;

	// cycles spent waiting for the returned word of one calibration attempt
	// covers the longest tap plus the selector pipeline with some margin
	localparam int CAL_WINDOW = LATENCY_NUM + 4;

	// width of the window counter in the calibrator, sized to hold CAL_WINDOW
	localparam int CAL_WINDOW_WIDTH = $clog2(CAL_WINDOW + 1);

endpackage

// ==== source/phy_read_datapath.sv ====
// read path top level: latency shifter, latency calibrator and valid selector with their wiring
module phy_read_datapath (
	input  logic                                    pll_afi_clk,
	input  logic                                    reset_n,
	input  logic                                    ctl_rd_strobe,
	input  logic                                    cal_start,
	input  logic [phy_read_cfg_pkg::DATA_WIDTH-1:0] mem_rdata,
	output logic                                    mem_rd_strobe,
	output phy_read_types_pkg::afi_read_word_t      afi_rdata,
	output phy_read_types_pkg::cal_status_t         cal_status
);

	// test read strobe from the calibrator
	logic cal_rd_strobe;

	// calibration in progress, steers the strobe merge in the shifter
	logic cal_busy;

	// latency count chosen by the calibrator
	logic [phy_read_cfg_pkg::LATENCY_COUNT_WIDTH-1:0] latency_counter;

	// all taps of the latency chain
	logic [phy_read_cfg_pkg::LATENCY_NUM-1:0] latency_shifter;

	// strobes enter here and go out to the memory as read commands
	read_latency_shifter i_read_latency_shifter (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.ctl_rd_strobe   (ctl_rd_strobe),
		.cal_rd_strobe   (cal_rd_strobe),
		.cal_busy        (cal_busy),
		.mem_rd_strobe   (mem_rd_strobe),
		.latency_shifter (latency_shifter)
	);

	// the calibrator watches the same AFI word that leaves the top level
	read_latency_calibrator i_read_latency_calibrator (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.cal_start       (cal_start),
		.afi_rdata       (afi_rdata),
		.cal_rd_strobe   (cal_rd_strobe),
		.cal_busy        (cal_busy),
		.latency_counter (latency_counter),
		.cal_status      (cal_status)
	);

	// picks the tap for the current count and captures the returned word
	read_valid_selector i_read_valid_selector (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n         (reset_n),
		.latency_shifter (latency_shifter),
		.latency_counter (latency_counter),
		.mem_rdata       (mem_rdata),
		.afi_rdata       (afi_rdata)
	);

endmodule

// ==== source/phy_read_types_pkg.sv ====
// read path types: calibrator state enum, AFI read word struct and calibration status struct
package phy_read_types_pkg;

	// states of the read latency calibration FSM
	// idle waits for a start pulse, issue sends one test read,
	// wait watches the returned words, next judges the attempt
	// done and fail hold the final result until the next start
	typedef enum logic [2:0] {
		cal_idle,
		cal_issue,
		cal_wait,
		cal_next,
		cal_done,
		cal_fail
	} cal_state_e;

	// one read word as seen on the AFI side
	// valid is a single cycle pulse, data is only meaningful while valid is high
	typedef struct packed {
		logic                                   valid;
		logic [phy_read_cfg_pkg::DATA_WIDTH-1:0] data;
	} afi_read_word_t;

	// calibration status as reported to the controller
	// busy covers the whole search, success and fail are levels that hold
	// until the next start, latency mirrors the count used by the selector
	typedef struct packed {
		logic                                            busy;
		logic                                            success;
		logic                                            fail;
		logic [phy_read_cfg_pkg::LATENCY_COUNT_WIDTH-1:0] latency;
	} cal_status_t;

endpackage

// ==== source/read_latency_calibrator.sv ====
// read latency calibrator: FSM that searches the read latency with test reads and holds the count
module read_latency_calibrator (
	input  logic                                             pll_afi_clk,
	input  logic                                             reset_n,
	input  logic                                             cal_start,
	input  phy_read_types_pkg::afi_read_word_t               afi_rdata,
	output logic                                             cal_rd_strobe,
	output logic                                             cal_busy,
	output logic [phy_read_cfg_pkg::LATENCY_COUNT_WIDTH-1:0] latency_counter,
	output phy_read_types_pkg::cal_status_t                  cal_status
);

	// FSM state, current and next
	phy_read_types_pkg::cal_state_e state_q;
	phy_read_types_pkg::cal_state_e state_d;

	// latency count under test, also the final result once the search ends
	logic [phy_read_cfg_pkg::LATENCY_COUNT_WIDTH-1:0] latency_q;

	// cycles spent in the wait state of the current attempt
	logic [phy_read_cfg_pkg::CAL_WINDOW_WIDTH-1:0] window_q;

	// set once the current attempt has seen the expected pattern
	logic pass_q;

	// a start pulse is honoured only when no search is running
	logic start_ok;

	// last cycle of the wait window
	logic window_end;

	// the returned word matches the calibration pattern in this cycle
	logic pattern_hit;

	assign start_ok = cal_start &&
		(state_q == phy_read_types_pkg::cal_idle ||
		 state_q == phy_read_types_pkg::cal_done ||
		 state_q == phy_read_types_pkg::cal_fail);

	assign window_end = (window_q ==
		phy_read_cfg_pkg::CAL_WINDOW_WIDTH'(phy_read_cfg_pkg::CAL_WINDOW - 1));

	assign pattern_hit = afi_rdata.valid && (afi_rdata.data == phy_read_cfg_pkg::CAL_PATTERN);

	// next state logic
	// one attempt is issue (1 cycle), wait (CAL_WINDOW cycles) and next (1 cycle)
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			phy_read_types_pkg::cal_idle,
			phy_read_types_pkg::cal_done,
			phy_read_types_pkg::cal_fail:
			begin
				if (start_ok)
					state_d = phy_read_types_pkg::cal_issue;
			end
			phy_read_types_pkg::cal_issue:
			begin
				state_d = phy_read_types_pkg::cal_wait;
			end
			phy_read_types_pkg::cal_wait:
			begin
				if (window_end)
					state_d = phy_read_types_pkg::cal_next;
			end
			phy_read_types_pkg::cal_next:
			begin
				// a pass wins over the end of the count range
				if (pass_q)
					state_d = phy_read_types_pkg::cal_done;
				else if (&latency_q)
					state_d = phy_read_types_pkg::cal_fail;
				else
					state_d = phy_read_types_pkg::cal_issue;
			end
			default:
			begin
				state_d = phy_read_types_pkg::cal_idle;
			end
		endcase
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
			state_q <= phy_read_types_pkg::cal_idle;
		else
			state_q <= state_d;
	end

	// the count restarts from zero on every start and steps up after a failed attempt
	// it stays at the passing value in done and at the maximum in fail
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			latency_q <= '0;
		end
		else if (start_ok)
		begin
			latency_q <= '0;
		end
		else if (state_q == phy_read_types_pkg::cal_next && !pass_q && !(&latency_q))
		begin
			latency_q <= latency_q + 1'b1;
		end
	end

	// window counter and pass flag, both rearmed when the test read goes out
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			window_q <= '0;
			pass_q   <= 1'b0;
		end
		else if (state_q == phy_read_types_pkg::cal_issue)
		begin
			window_q <= '0;
			pass_q   <= 1'b0;
		end
		else if (state_q == phy_read_types_pkg::cal_wait)
		begin
			window_q <= window_q + 1'b1;
			// only a word flagged valid by the selector counts,
			// so the pattern must line up with the count under test
			if (pattern_hit)
				pass_q <= 1'b1;
		end
	end

	// one test read per attempt, sampled by the shifter as the FSM leaves issue
	assign cal_rd_strobe = (state_q == phy_read_types_pkg::cal_issue);

	// busy spans the whole search and gives the read path to the calibrator
	assign cal_busy = (state_q == phy_read_types_pkg::cal_issue) ||
		(state_q == phy_read_types_pkg::cal_wait) ||
		(state_q == phy_read_types_pkg::cal_next);

	assign latency_counter = latency_q;

	// busy drops in the same cycle that success or fail comes up
	assign cal_status = '{
		busy:    cal_busy,
		success: (state_q == phy_read_types_pkg::cal_done),
		fail:    (state_q == phy_read_types_pkg::cal_fail),
		latency: latency_q
	};

endmodule

// ==== source/read_latency_shifter.sv ====
// read latency shifter: merges read strobes, drives the memory read command, shifts the taps
module read_latency_shifter (
	input  logic                                     pll_afi_clk,
	input  logic                                     reset_n,
	input  logic                                     ctl_rd_strobe,
	input  logic                                     cal_rd_strobe,
	input  logic                                     cal_busy,
	output logic                                     mem_rd_strobe,
	output logic [phy_read_cfg_pkg::LATENCY_NUM-1:0] latency_shifter
);

	// strobe chosen for this cycle, before it enters tap 0
	logic rd_strobe_merged;

	// taps of the latency chain, bit k is the strobe delayed by k+1 edges
	logic [phy_read_cfg_pkg::LATENCY_NUM-1:0] shift_q;

	// calibration owns the read path while it is busy
	// controller strobes that arrive meanwhile are dropped on purpose,
	// the controller is not expected to read before calibration ends
	always_comb
	begin
		if (cal_busy)
			rd_strobe_merged = cal_rd_strobe;
		else
			rd_strobe_merged = ctl_rd_strobe;
	end

	// the chain moves one place per cycle and takes the new strobe into tap 0
	// every tap is a plain flop so back to back strobes are kept apart
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			shift_q <= '0;
		end
		else
		begin
			shift_q <= {shift_q[phy_read_cfg_pkg::LATENCY_NUM-2:0], rd_strobe_merged};
		end
	end

	// tap 0 is the registered strobe and goes straight out as the read command
	assign mem_rd_strobe = shift_q[0];

	// all taps go to the valid selector, which picks one by latency count
	assign latency_shifter = shift_q;

endmodule

// ==== source/read_valid_selector.sv ====
// read valid selector: decodes the latency count, masks the shifter taps, registers valid and data
module read_valid_selector (
	input  logic                                             pll_afi_clk,
	input  logic                                             reset_n,
	input  logic [phy_read_cfg_pkg::LATENCY_NUM-1:0]         latency_shifter,
	input  logic [phy_read_cfg_pkg::LATENCY_COUNT_WIDTH-1:0] latency_counter,
	input  logic [phy_read_cfg_pkg::DATA_WIDTH-1:0]          mem_rdata,
	output phy_read_types_pkg::afi_read_word_t               afi_rdata
);

	// one-hot form of the latency count, straight from the decoder
	logic [phy_read_cfg_pkg::LATENCY_NUM-1:0] selector;

	// registered one-hot select, one cycle behind the count
	logic [phy_read_cfg_pkg::LATENCY_NUM-1:0] selector_reg;

	// taps that survive the mask, registered
	logic [phy_read_cfg_pkg::LATENCY_NUM-1:0] valid_select_reg;

	// outgoing valid pulse and captured word
	logic                                    read_valid;
	logic [phy_read_cfg_pkg::DATA_WIDTH-1:0] read_data;

	// decoder, bit n is set when the count equals n
	assign selector = {{(phy_read_cfg_pkg::LATENCY_NUM - 1){1'b0}}, 1'b1} << latency_counter;

	// a count of k picks tap k, then two more flops give a total latency of k+2
	always_ff @(posedge pll_afi_clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			selector_reg     <= '0;
			valid_select_reg <= '0;
			read_valid       <= 1'b0;
		end
		else
		begin
			selector_reg     <= selector;
			valid_select_reg <= selector_reg & latency_shifter;
			read_valid       <= |valid_select_reg;
		end
	end

	// the memory word is captured every cycle at the same edge as valid
	// so data lines up with the pulse without any extra tracking
	always_ff @(posedge pll_afi_clk)
	begin
		read_data <= mem_rdata;
	end

	assign afi_rdata = '{valid: read_valid, data: read_data};

endmodule

// ==== tb/phy_read_datapath_tb.sv ====
// read path testbench: clock and reset, memory delay model, read scoreboard and the test sequence
module phy_read_datapath_tb;

	// DUT ports
	logic                                    pll_afi_clk;
	logic                                    reset_n;
	logic                                    ctl_rd_strobe;
	logic                                    cal_start;
	logic [phy_read_cfg_pkg::DATA_WIDTH-1:0] mem_rdata;
	logic                                    mem_rd_strobe;
	phy_read_types_pkg::afi_read_word_t      afi_rdata;
	phy_read_types_pkg::cal_status_t         cal_status;

	// rising edges seen so far, every word of the model is keyed to an edge number
	int unsigned edge_cnt;

	// memory delay D in cycles, from the sampling edge of a strobe to the edge that takes the word
	int unsigned mem_delay;

	// words the memory still has to return, with the edge that must sample each one
	int unsigned                             mem_due[$];
	logic [phy_read_cfg_pkg::DATA_WIDTH-1:0] mem_word[$];

	// controller reads still expected on the AFI side, with the edge of their valid pulse
	int unsigned                             exp_due[$];
	logic [phy_read_cfg_pkg::DATA_WIDTH-1:0] exp_word[$];

	// the scoreboard only runs while controller reads are under test
	bit check_en;

	// valid pulses seen by the scoreboard and read commands seen by the memory
	int unsigned valid_count;
	int unsigned cmd_count;

	string       test_name;
	int unsigned seed_sink;

	phy_read_datapath i_dut (
		.pll_afi_clk   (pll_afi_clk),
		.reset_n       (reset_n),
		.ctl_rd_strobe (ctl_rd_strobe),
		.cal_start     (cal_start),
		.mem_rdata     (mem_rdata),
		.mem_rd_strobe (mem_rd_strobe),
		.afi_rdata     (afi_rdata),
		.cal_status    (cal_status)
	);

	// 10 unit clock
	always #5 pll_afi_clk = ~pll_afi_clk;

	always @(posedge pll_afi_clk)
	begin
		edge_cnt <= edge_cnt + 1;
	end

	// prints the cause, then the fail message, then ends the run
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
			stop_on_error($sformatf("ERR %s %s: expected %h actual %h",
				test_name, what, expected, actual));
	endtask

	// filler word for cycles without a read, never the calibration pattern
	function automatic logic [31:0] random_idle_word();
		logic [31:0] w;
		w = $urandom;
		while (w == phy_read_cfg_pkg::CAL_PATTERN)
			w = $urandom;
		return w;
	endfunction

	// 16 attempts of issue, wait window and next, plus some slack
	function automatic int unsigned cal_timeout();
		return phy_read_cfg_pkg::LATENCY_NUM * (2 + phy_read_cfg_pkg::CAL_WINDOW) + 16;
	endfunction

	// a valid pulse must match the oldest outstanding read, both in edge and in data
	task automatic score_read();
		if (afi_rdata.valid)
		begin
			valid_count++;
			assert (exp_due.size() > 0)
			else
				stop_on_error($sformatf("%s saw a valid pulse with no read outstanding",
					test_name));
			check_value("valid edge", exp_due[0], edge_cnt);
			check_value("data", exp_word[0], afi_rdata.data);
			void'(exp_due.pop_front());
			void'(exp_word.pop_front());
		end
		else
		begin
			// the oldest read is due at this edge, so the pulse is missing
			assert (exp_due.size() == 0 || exp_due[0] > edge_cnt)
			else
				check_value("valid", 1, afi_rdata.valid);
		end
	endtask

	// tap 0 came up at the last rising edge, which is the sampling edge t of the strobe
	task automatic accept_command();
		logic [31:0] word;
		if (mem_rd_strobe)
		begin
			cmd_count++;
			if (cal_status.busy)
				word = phy_read_cfg_pkg::CAL_PATTERN;
			else
				word = $urandom;
			mem_due.push_back(edge_cnt + mem_delay);
			mem_word.push_back(word);
			if (check_en && !cal_status.busy)
			begin
				exp_due.push_back(edge_cnt + mem_delay);
				exp_word.push_back(word);
			end
		end
	endtask

	// put the word due at the next rising edge on the bus, or filler otherwise
	task automatic drive_memory();
		if (mem_due.size() > 0 && mem_due[0] == edge_cnt + 1)
		begin
			mem_rdata = mem_word.pop_front();
			void'(mem_due.pop_front());
		end
		else
		begin
			mem_rdata = random_idle_word();
		end
	endtask

	// memory model and scoreboard, both working on the falling edge
	always @(negedge pll_afi_clk)
	begin
		if (!reset_n)
		begin
			mem_due.delete();
			mem_word.delete();
			exp_due.delete();
			exp_word.delete();
			mem_rdata = random_idle_word();
		end
		else
		begin
			if (check_en)
				score_read();
			accept_command();
			drive_memory();
		end
	end

	task automatic check_idle_outputs();
		check_value("mem_rd_strobe", 0, mem_rd_strobe);
		check_value("valid", 0, afi_rdata.valid);
		check_value("busy", 0, cal_status.busy);
		check_value("success", 0, cal_status.success);
		check_value("fail", 0, cal_status.fail);
		check_value("latency", 0, cal_status.latency);
	endtask

	// reset held for 3 rising edges, the model delay is loaded while the model is in reset
	task automatic apply_reset(input int unsigned delay);
		reset_n = 1'b0;
		repeat (3)
		begin
			@(negedge pll_afi_clk);
			mem_delay = delay;
			check_idle_outputs();
		end
		reset_n = 1'b1;
	endtask

	task automatic pulse_cal_start();
		cal_start = 1'b1;
		@(negedge pll_afi_clk);
		cal_start = 1'b0;
	endtask

	// waits until every expected read has come back
	task automatic wait_for_drain();
		int unsigned cycles;
		cycles = 0;
		@(posedge pll_afi_clk);
		while (exp_due.size() != 0 && cycles < phy_read_cfg_pkg::LATENCY_NUM + 8)
		begin
			@(posedge pll_afi_clk);
			cycles++;
		end
		assert (exp_due.size() == 0)
		else
			stop_on_error($sformatf("%s timed out waiting for outstanding reads", test_name));
		@(negedge pll_afi_clk);
	endtask

	task automatic test_reset_state(input int unsigned delay);
		test_name = "reset_state";
		apply_reset(delay);
		@(negedge pll_afi_clk);
		check_idle_outputs();
	endtask

	task automatic test_calibration_lock();
		int unsigned cycles;
		test_name = "calibration_lock";
		pulse_cal_start();
		cycles = 0;
		while (!cal_status.success && cycles < cal_timeout())
		begin
			check_value("fail", 0, cal_status.fail);
			check_value("busy", 1, cal_status.busy);
			@(negedge pll_afi_clk);
			cycles++;
		end
		assert (cal_status.success)
		else
			stop_on_error("calibration did not lock before the timeout");
		check_value("fail", 0, cal_status.fail);
		check_value("busy", 0, cal_status.busy);
		// whole path latency is the count plus 2
		check_value("latency", mem_delay - 2, cal_status.latency);
	endtask

	task automatic test_single_read();
		int unsigned valid_base;
		test_name = "single_read";
		@(posedge pll_afi_clk);
		check_en = 1'b1;
		valid_base = valid_count;
		@(negedge pll_afi_clk);
		check_value("mem_rd_strobe", 0, mem_rd_strobe);
		ctl_rd_strobe = 1'b1;
		@(negedge pll_afi_clk);
		ctl_rd_strobe = 1'b0;
		check_value("mem_rd_strobe", 1, mem_rd_strobe);
		@(negedge pll_afi_clk);
		check_value("mem_rd_strobe", 0, mem_rd_strobe);
		wait_for_drain();
		// quiet window, a stray pulse here has no expected entry and is caught by the scoreboard
		repeat (phy_read_cfg_pkg::LATENCY_NUM + 4)
			@(negedge pll_afi_clk);
		@(posedge pll_afi_clk);
		check_value("valid pulses", valid_base + 1, valid_count);
		@(negedge pll_afi_clk);
	endtask

	task automatic test_burst_reads();
		int unsigned strobes;
		int unsigned valid_base;
		int unsigned cmd_base;
		test_name = "burst_reads";
		@(posedge pll_afi_clk);
		valid_base = valid_count;
		cmd_base = cmd_count;
		@(negedge pll_afi_clk);
		strobes = 0;
		// two out of three cycles carry a strobe, so back to back reads are common
		repeat (300)
		begin
			ctl_rd_strobe = (($urandom % 3) != 0);
			strobes += ctl_rd_strobe;
			@(negedge pll_afi_clk);
		end
		ctl_rd_strobe = 1'b0;
		wait_for_drain();
		repeat (phy_read_cfg_pkg::LATENCY_NUM + 4)
			@(negedge pll_afi_clk);
		@(posedge pll_afi_clk);
		check_value("read commands", strobes, cmd_count - cmd_base);
		check_value("valid pulses", strobes, valid_count - valid_base);
		@(negedge pll_afi_clk);
	endtask

	// a delay of 20 is beyond the longest tap, so every attempt must miss
	task automatic test_calibration_failure();
		int unsigned cycles;
		test_name = "calibration_failure";
		@(posedge pll_afi_clk);
		check_en = 1'b0;
		@(negedge pll_afi_clk);
		apply_reset(20);
		@(negedge pll_afi_clk);
		pulse_cal_start();
		cycles = 0;
		while (!cal_status.fail && cycles < cal_timeout())
		begin
			check_value("success", 0, cal_status.success);
			@(negedge pll_afi_clk);
			cycles++;
		end
		assert (cal_status.fail)
		else
			stop_on_error("calibration did not report failure before the timeout");
		check_value("success", 0, cal_status.success);
		check_value("busy", 0, cal_status.busy);
		check_value("latency", phy_read_cfg_pkg::LATENCY_NUM - 1, cal_status.latency);
	endtask

	initial
	begin
		seed_sink = $urandom(32'hba61_ae9c);
		pll_afi_clk = 1'b0;
		reset_n = 1'b0;
		ctl_rd_strobe = 1'b0;
		cal_start = 1'b0;
		mem_rdata = '0;
		edge_cnt = 0;
		check_en = 1'b0;
		valid_count = 0;
		cmd_count = 0;
		mem_delay = 3;
		// memory delay for the lock and read tests, 3 to 16 cycles
		test_reset_state(3 + ($urandom % 14));
		test_calibration_lock();
		test_single_read();
		test_burst_reads();
		test_calibration_failure();
		$display("all tests passed");
		$finish;
	end

endmodule
